// ==== hdl/ttc_pkg.sv ====
/*
  Shared constants for one timer channel behind an 8-bit APB address space.
  Registers are 16 bits wide on word addresses. Only ctrl, interval, match,
  prescale and intr_enable are writable. Status is cleared by reading it.
*/
package ttc_pkg;

  // ------------------------------
  // Bus widths
  // ------------------------------
  localparam int addr_w = 8;           // APB address
  localparam int data_w = 16;          // Register and counter width

  // Register word addresses
  typedef enum logic [addr_w-1:0] {
    ctrl        = 8'h00,
    interval    = 8'h04,
    match1      = 8'h08,
    match2      = 8'h0C,
    match3      = 8'h10,
    count       = 8'h14,               // Read only
    prescale    = 8'h18,
    intr_status = 8'h1C,               // Cleared on read
    intr_enable = 8'h20
  } ttc_addr_e;

  // ------------------------------
  // Control register
  // ------------------------------
  localparam int ctrl_w            = 7;
  localparam logic [ctrl_w-1:0] ctrl_reset = 7'h01;  // Counter starts disabled
  localparam int ctrl_dis_bit      = 0;  // Active high counter disable
  localparam int ctrl_interval_bit = 1;  // Interval mode when set, else overflow
  localparam int ctrl_decr_bit     = 2;  // Count down
  localparam int ctrl_match_bit    = 3;  // Match events on
  localparam int ctrl_restart_bit  = 4;  // Self-clearing restart
  localparam int ctrl_wave_dis_bit = 5;  // Stored only
  localparam int ctrl_wave_pol_bit = 6;  // Stored only

  // Mode as {interval, decr}
  typedef enum logic [1:0] {
    overflow_up   = 2'b00,
    overflow_down = 2'b01,
    interval_up   = 2'b10,
    interval_down = 2'b11
  } ttc_cnt_mode_e;

  // ------------------------------
  // Interrupts and prescaler
  // ------------------------------
  localparam int intr_w        = 5;
  localparam int intr_interval = 0;
  localparam int intr_match1   = 1;
  localparam int intr_match2   = 2;
  localparam int intr_match3   = 3;
  localparam int intr_overflow = 4;

  localparam int presc_w = 5;          // Enable in bit 4 and N in bits 3..0

endpackage

// ==== hdl/ttc_reg_if.sv ====
/*
  Link between the APB register bank and the counter block.
  Selects are single-cycle write strobes qualified by the APB access cycle.
  intr_raw is combinational and gets sampled by the bank's status logic.
*/
interface ttc_reg_if (
  input logic pclk5,
  input logic n_p_reset5
);

  // Bank to counter
  logic [ttc_pkg::data_w-1:0] wdata;          // Copy of pwdata
  logic                       ctrl_sel;
  logic                       interval_sel;
  logic [2:0]                 match_sel;      // Bit 0 is match1

  // Counter to bank
  logic [ttc_pkg::ctrl_w-1:0] ctrl_val;
  logic [ttc_pkg::data_w-1:0] interval_val;
  logic [ttc_pkg::data_w-1:0] match1_val;
  logic [ttc_pkg::data_w-1:0] match2_val;
  logic [ttc_pkg::data_w-1:0] match3_val;
  logic [ttc_pkg::data_w-1:0] count_val;
  logic [ttc_pkg::intr_w-1:0] intr_raw;       // Event level only

  modport regbank (
    input  pclk5, n_p_reset5,
    output wdata, ctrl_sel, interval_sel, match_sel,
    input  ctrl_val, interval_val, match1_val, match2_val, match3_val,
    input  count_val, intr_raw
  );

  modport counter (
    input  pclk5, n_p_reset5,
    input  wdata, ctrl_sel, interval_sel, match_sel,
    output ctrl_val, interval_val, match1_val, match2_val, match3_val,
    output count_val, intr_raw
  );

endinterface

// ==== hdl/ttc_prescaler.sv ====
/*
  Count enable generator. Disabled means count_en stays high every cycle.
  Enabled gives one pulse per 2^(N+1) clocks, N from 0 to 15.
  Any change of presc_cfg restarts the divide from zero.
*/
module ttc_prescaler (
  input  logic                        pclk5,
  input  logic                        n_p_reset5,
  input  logic [ttc_pkg::presc_w-1:0] presc_cfg,
  output logic                        count_en
);

  logic       presc_on;                // Enable bit of the config
  logic [4:0] shift_amt;               // N+1, up to 16
  logic [16:0] ratio;                  // 2^(N+1)
  logic [16:0] ratio_m1;
  logic [15:0] term_cnt;               // Last divider value of a period
  logic [15:0] div_cnt;
  logic [ttc_pkg::presc_w-1:0] cfg_q;  // Config seen last cycle
  logic       cfg_changed;
  logic       at_term;

  assign presc_on    = presc_cfg[ttc_pkg::presc_w-1];
  assign shift_amt   = {1'b0, presc_cfg[3:0]} + 5'd1;
  assign ratio       = 17'd1 << shift_amt;
  assign ratio_m1    = ratio - 17'd1;
  assign term_cnt    = ratio_m1[15:0];
  assign cfg_changed = (presc_cfg != cfg_q);
  assign at_term     = (div_cnt == term_cnt);

  // ------------------------------
  // Divider
  // ------------------------------
  always_ff @(posedge pclk5 or negedge n_p_reset5)
  begin
    if (!n_p_reset5)
    begin
      cfg_q   <= '0;
      div_cnt <= '0;
    end
    else
    begin
      cfg_q <= presc_cfg;
      if (cfg_changed || !presc_on)
        div_cnt <= '0;                 // Restart the period
      else if (at_term)
        div_cnt <= '0;                 // Wrap
      else
        div_cnt <= div_cnt + 16'd1;
    end
  end

  // Pulse only at terminal count and never in the cycle of a config change
  assign count_en = presc_on ? (at_term && !cfg_changed) : 1'b1;

endmodule

// ==== hdl/ttc_counter_lite.sv ====
/*
  16-bit up/down counter with interval and overflow modes and three matches.
  Counter and restart only act on cycles with count_en high.
  Interval is taken as static while counting. Events are combinational.
*/
module ttc_counter_lite (
  input  logic           pclk5,
  input  logic           n_p_reset5,
  input  logic           count_en,       // From the prescaler
  ttc_reg_if.counter     regs
);

  logic [ttc_pkg::ctrl_w-1:0] ctrl_q;
  logic [ttc_pkg::data_w-1:0] interval_q;
  logic [ttc_pkg::data_w-1:0] match_q [3];
  logic [ttc_pkg::data_w-1:0] count_q;
  logic                       counting;      // Stepped since last restart
  logic                       restart_done;  // Restart was applied last edge

  ttc_pkg::ttc_cnt_mode_e     mode;
  logic [ttc_pkg::data_w-1:0] next_count;
  logic [ttc_pkg::data_w-1:0] start_val;
  logic                       events_on;
  logic                       count_zero;

  // ------------------------------
  // Register writes
  // ------------------------------
  always_ff @(posedge pclk5 or negedge n_p_reset5)
  begin
    if (!n_p_reset5)
    begin
      ctrl_q     <= ttc_pkg::ctrl_reset;
      interval_q <= '0;
    end
    else
    begin
      if (regs.ctrl_sel)
        ctrl_q <= regs.wdata[ttc_pkg::ctrl_w-1:0];
      else if (restart_done)
        ctrl_q[ttc_pkg::ctrl_restart_bit] <= 1'b0;  // Self clear
      if (regs.interval_sel)
        interval_q <= regs.wdata;
    end
  end

  // Three identical match registers
  always_ff @(posedge pclk5 or negedge n_p_reset5)
  begin
    if (!n_p_reset5)
    begin
      for (int i = 0; i < 3; i++)
        match_q[i] <= '0;
    end
    else
    begin
      for (int i = 0; i < 3; i++)
        if (regs.match_sel[i])
          match_q[i] <= regs.wdata;
    end
  end

  // ------------------------------
  // Counter step and restart
  // ------------------------------
  assign mode = ttc_pkg::ttc_cnt_mode_e'({ctrl_q[ttc_pkg::ctrl_interval_bit],
                                          ctrl_q[ttc_pkg::ctrl_decr_bit]});
  assign count_zero = (count_q == '0);

  always_comb
  begin
    case (mode)
      ttc_pkg::overflow_up:   next_count = count_q + 16'd1;  // Wraps at FFFF
      ttc_pkg::overflow_down: next_count = count_q - 16'd1;  // Wraps at 0
      ttc_pkg::interval_up:
        next_count = (count_q == interval_q) ? '0 : count_q + 16'd1;
      ttc_pkg::interval_down:
        next_count = count_zero ? interval_q : count_q - 16'd1;
      default:                next_count = count_q;
    endcase
  end

  // Up counts restart from 0, down counts from the top of their range
  always_comb
  begin
    if (!ctrl_q[ttc_pkg::ctrl_decr_bit])
      start_val = '0;
    else if (ctrl_q[ttc_pkg::ctrl_interval_bit])
      start_val = interval_q;
    else
      start_val = 16'hFFFF;
  end

  always_ff @(posedge pclk5 or negedge n_p_reset5)
  begin
    if (!n_p_reset5)
    begin
      count_q      <= '0;
      counting     <= 1'b0;
      restart_done <= 1'b0;
    end
    else
    begin
      restart_done <= 1'b0;                       // One-cycle strobe
      if (count_en)
      begin
        if (ctrl_q[ttc_pkg::ctrl_restart_bit])
        begin
          count_q      <= start_val;              // Applies even when disabled
          counting     <= 1'b0;
          restart_done <= 1'b1;
        end
        else if (!ctrl_q[ttc_pkg::ctrl_dis_bit])
        begin
          count_q  <= next_count;
          counting <= 1'b1;
        end
      end
    end
  end

  // ------------------------------
  // Events
  // ------------------------------
  assign events_on = counting && !ctrl_q[ttc_pkg::ctrl_dis_bit]
                     && !ctrl_q[ttc_pkg::ctrl_restart_bit];

  assign regs.intr_raw[ttc_pkg::intr_interval] =
    events_on && ctrl_q[ttc_pkg::ctrl_interval_bit] && count_zero;
  assign regs.intr_raw[ttc_pkg::intr_overflow] =
    events_on && !ctrl_q[ttc_pkg::ctrl_interval_bit] && count_zero;
  assign regs.intr_raw[ttc_pkg::intr_match1] =
    events_on && ctrl_q[ttc_pkg::ctrl_match_bit] && (count_q == match_q[0]);
  assign regs.intr_raw[ttc_pkg::intr_match2] =
    events_on && ctrl_q[ttc_pkg::ctrl_match_bit] && (count_q == match_q[1]);
  assign regs.intr_raw[ttc_pkg::intr_match3] =
    events_on && ctrl_q[ttc_pkg::ctrl_match_bit] && (count_q == match_q[2]);

  // Readback
  assign regs.ctrl_val     = ctrl_q;
  assign regs.interval_val = interval_q;
  assign regs.match1_val   = match_q[0];
  assign regs.match2_val   = match_q[1];
  assign regs.match3_val   = match_q[2];
  assign regs.count_val    = count_q;

endmodule

// ==== hdl/ttc_regbank.sv ====
/*
  APB slave without wait states or error response, two cycles per transfer.
  prdata is driven only in read access cycles, zero otherwise.
  Unmapped addresses read zero, and writes to them are dropped.
*/
module ttc_regbank (
  input  logic                        pclk5,
  input  logic                        n_p_reset5,
  input  logic                        psel,
  input  logic                        penable,
  input  logic                        pwrite,
  input  logic [ttc_pkg::addr_w-1:0]  paddr,
  input  logic [ttc_pkg::data_w-1:0]  pwdata,
  output logic [ttc_pkg::data_w-1:0]  prdata,
  output logic                        irq,
  output logic [ttc_pkg::presc_w-1:0] presc_cfg,
  ttc_reg_if.regbank                  regs
);

  logic                       access;      // APB access phase
  logic                       wr_en;
  logic                       rd_en;
  logic                       status_rd;   // Read of intr_status
  logic                       presc_sel;
  logic                       enable_sel;
  logic [ttc_pkg::presc_w-1:0] presc_q;
  logic [ttc_pkg::intr_w-1:0] status_q;    // Sticky
  logic [ttc_pkg::intr_w-1:0] enable_q;
  logic [ttc_pkg::data_w-1:0] rd_mux;

  assign access = psel && penable;
  assign wr_en  = access && pwrite;
  assign rd_en  = access && !pwrite;

  // ------------------------------
  // Write decode
  // ------------------------------
  assign regs.wdata        = pwdata;
  assign regs.ctrl_sel     = wr_en && (paddr == ttc_pkg::ctrl);
  assign regs.interval_sel = wr_en && (paddr == ttc_pkg::interval);
  assign regs.match_sel[0] = wr_en && (paddr == ttc_pkg::match1);
  assign regs.match_sel[1] = wr_en && (paddr == ttc_pkg::match2);
  assign regs.match_sel[2] = wr_en && (paddr == ttc_pkg::match3);
  assign presc_sel         = wr_en && (paddr == ttc_pkg::prescale);
  assign enable_sel        = wr_en && (paddr == ttc_pkg::intr_enable);
  assign status_rd         = rd_en && (paddr == ttc_pkg::intr_status);

  // Local registers
  always_ff @(posedge pclk5 or negedge n_p_reset5)
  begin
    if (!n_p_reset5)
    begin
      presc_q  <= '0;
      enable_q <= '0;
    end
    else
    begin
      if (presc_sel)
        presc_q <= pwdata[ttc_pkg::presc_w-1:0];
      if (enable_sel)
        enable_q <= pwdata[ttc_pkg::intr_w-1:0];
    end
  end

  assign presc_cfg = presc_q;

  // ------------------------------
  // Interrupt status and irq
  // ------------------------------
  always_ff @(posedge pclk5 or negedge n_p_reset5)
  begin
    if (!n_p_reset5)
    begin
      status_q <= '0;
      irq      <= 1'b0;
    end
    else
    begin
      // New events win over a clear in the same cycle
      status_q <= (status_q & ~{ttc_pkg::intr_w{status_rd}}) | regs.intr_raw;
      irq      <= |(status_q & enable_q);   // One cycle behind status
    end
  end

  // ------------------------------
  // Read mux
  // ------------------------------
  always_comb
  begin
    case (paddr)
      ttc_pkg::ctrl:
        rd_mux = {{(ttc_pkg::data_w-ttc_pkg::ctrl_w){1'b0}}, regs.ctrl_val};
      ttc_pkg::interval:    rd_mux = regs.interval_val;
      ttc_pkg::match1:      rd_mux = regs.match1_val;
      ttc_pkg::match2:      rd_mux = regs.match2_val;
      ttc_pkg::match3:      rd_mux = regs.match3_val;
      ttc_pkg::count:       rd_mux = regs.count_val;
      ttc_pkg::prescale:
        rd_mux = {{(ttc_pkg::data_w-ttc_pkg::presc_w){1'b0}}, presc_q};
      ttc_pkg::intr_status:
        rd_mux = {{(ttc_pkg::data_w-ttc_pkg::intr_w){1'b0}}, status_q};
      ttc_pkg::intr_enable:
        rd_mux = {{(ttc_pkg::data_w-ttc_pkg::intr_w){1'b0}}, enable_q};
      default:              rd_mux = '0;    // Unmapped
    endcase
  end

  assign prdata = rd_en ? rd_mux : '0;

endmodule

// ==== hdl/ttc_timer.sv ====
/*
  One timer channel with APB access and a single level interrupt.
  No waveform output and no external clock source.
*/
module ttc_timer (
  input  logic                       pclk5,
  input  logic                       n_p_reset5,
  input  logic                       psel,
  input  logic                       penable,
  input  logic                       pwrite,
  input  logic [ttc_pkg::addr_w-1:0] paddr,
  input  logic [ttc_pkg::data_w-1:0] pwdata,
  output logic [ttc_pkg::data_w-1:0] prdata,
  output logic                       irq
);

  logic                        count_en;    // Prescaler to counter
  logic [ttc_pkg::presc_w-1:0] presc_cfg;   // Bank to prescaler

  // ------------------------------
  // Register link
  // ------------------------------
  ttc_reg_if regs (
    .pclk5      (pclk5),
    .n_p_reset5 (n_p_reset5)
  );

  // APB side
  ttc_regbank u_regbank (
    .pclk5      (pclk5),
    .n_p_reset5 (n_p_reset5),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .irq        (irq),
    .presc_cfg  (presc_cfg),
    .regs       (regs.regbank)
  );

  // Count enable source
  ttc_prescaler u_prescaler (
    .pclk5      (pclk5),
    .n_p_reset5 (n_p_reset5),
    .presc_cfg  (presc_cfg),
    .count_en   (count_en)
  );

  ttc_counter_lite u_counter (
    .pclk5      (pclk5),
    .n_p_reset5 (n_p_reset5),
    .count_en   (count_en),
    .regs       (regs.counter)
  );

endmodule

// ==== bench/ttc_tb_table.svh ====
/*
  Test table. Columns are op, addr, data, exp and check kind.
  Range checks keep the low bound in data and the high bound in exp.
  Wait entries keep the cycle count in data.
*/
typedef enum {op_wr, op_rd, op_wait, op_irq} op_e;
typedef enum {ck_none, ck_reg, ck_status, ck_range, ck_irq} chk_e;

typedef struct {
  op_e                        op;
  ttc_pkg::ttc_addr_e         addr;
  logic [ttc_pkg::data_w-1:0] data;
  logic [ttc_pkg::data_w-1:0] exp;
  chk_e                       kind;
} entry_t;

entry_t tbl[$];

// Control word from a counting mode and the flag bits
function automatic logic [ttc_pkg::data_w-1:0] ctrl_word(ttc_pkg::ttc_cnt_mode_e m,
                                                          logic dis, logic mat, logic rst);
  ctrl_word = '0;
  {ctrl_word[ttc_pkg::ctrl_interval_bit], ctrl_word[ttc_pkg::ctrl_decr_bit]} = m;
  ctrl_word[ttc_pkg::ctrl_dis_bit]     = dis;
  ctrl_word[ttc_pkg::ctrl_match_bit]   = mat;
  ctrl_word[ttc_pkg::ctrl_restart_bit] = rst;
endfunction

task automatic push(op_e op, ttc_pkg::ttc_addr_e a, logic [ttc_pkg::data_w-1:0] d,
                    logic [ttc_pkg::data_w-1:0] x, chk_e k);
  entry_t e;
  e.op   = op;
  e.addr = a;
  e.data = d;
  e.exp  = x;
  e.kind = k;
  tbl.push_back(e);
endtask

task automatic build_table();
  ttc_pkg::ttc_addr_e         rw_addr[4];
  logic [ttc_pkg::data_w-1:0] rv[4];
  ttc_pkg::ttc_addr_e         a;
  rw_addr = '{ttc_pkg::interval, ttc_pkg::match1, ttc_pkg::match2, ttc_pkg::match3};
  // ------------------------------
  // Reset values over the whole map
  a = ttc_pkg::ctrl;
  do
  begin
    push(op_rd, a, '0, (a == ttc_pkg::ctrl) ? 16'h0001 : 16'h0000,
         (a == ttc_pkg::intr_status) ? ck_status : ck_reg);
    a = a.next();
  end
  while (a != ttc_pkg::ctrl);
  push(op_irq, ttc_pkg::ctrl, '0, '0, ck_irq);
  // Top bit set keeps readback values far from the small counts below
  foreach (rw_addr[i])
  begin
    rv[i] = 16'($urandom) | 16'h8000;
    push(op_wr, rw_addr[i], rv[i], '0, ck_none);
  end
  foreach (rw_addr[i])
    push(op_rd, rw_addr[i], '0, rv[i], ck_reg);
  push(op_wr, ttc_pkg::ctrl, 16'hFFE1, '0, ck_none);
  push(op_rd, ttc_pkg::ctrl, '0, 16'h0061, ck_reg);            // Only 7 bits kept
  // ------------------------------
  // Interval up with an event on each return to zero
  push(op_wr, ttc_pkg::interval, 16'd5, '0, ck_none);
  push(op_wr, ttc_pkg::intr_enable, 16'(1 << ttc_pkg::intr_interval), '0, ck_none);
  push(op_wr, ttc_pkg::ctrl, ctrl_word(ttc_pkg::interval_up, 0, 0, 0), '0, ck_none);
  push(op_wait, ttc_pkg::ctrl, 16'd20, '0, ck_none);
  push(op_wr, ttc_pkg::ctrl, ctrl_word(ttc_pkg::interval_up, 1, 0, 0), '0, ck_none);
  push(op_irq, ttc_pkg::ctrl, '0, 16'd1, ck_irq);
  push(op_rd, ttc_pkg::count, 16'd0, 16'd5, ck_range);       // Never above interval
  push(op_rd, ttc_pkg::intr_status, '0, 16'(1 << ttc_pkg::intr_interval), ck_status);
  push(op_rd, ttc_pkg::intr_status, '0, '0, ck_status);      // Cleared by the read
  push(op_irq, ttc_pkg::ctrl, '0, '0, ck_irq);
  // Match2 hit while counting up from a restart
  push(op_wr, ttc_pkg::match2, 16'd3, '0, ck_none);
  push(op_wr, ttc_pkg::intr_enable, 16'h000E, '0, ck_none); // All three match bits
  push(op_wr, ttc_pkg::ctrl, ctrl_word(ttc_pkg::overflow_up, 1, 0, 1), '0, ck_none);
  push(op_wait, ttc_pkg::ctrl, 16'd2, '0, ck_none);
  push(op_wr, ttc_pkg::ctrl, ctrl_word(ttc_pkg::overflow_up, 0, 1, 0), '0, ck_none);
  push(op_wait, ttc_pkg::ctrl, 16'd10, '0, ck_none);
  push(op_wr, ttc_pkg::ctrl, ctrl_word(ttc_pkg::overflow_up, 1, 1, 0), '0, ck_none);
  push(op_rd, ttc_pkg::intr_status, '0, 16'(1 << ttc_pkg::intr_match2), ck_status);
  // ------------------------------
  // Restart while disabled loads the top of the range for down counts
  push(op_wr, ttc_pkg::interval, 16'd9, '0, ck_none);
  push(op_wr, ttc_pkg::ctrl, ctrl_word(ttc_pkg::interval_down, 1, 0, 1), '0, ck_none);
  push(op_wait, ttc_pkg::ctrl, 16'd2, '0, ck_none);
  push(op_rd, ttc_pkg::count, '0, 16'd9, ck_reg);
  push(op_rd, ttc_pkg::ctrl, '0, ctrl_word(ttc_pkg::interval_down, 1, 0, 0), ck_reg);
  push(op_wr, ttc_pkg::ctrl, ctrl_word(ttc_pkg::overflow_down, 1, 0, 1), '0, ck_none);
  push(op_wait, ttc_pkg::ctrl, 16'd2, '0, ck_none);
  push(op_rd, ttc_pkg::count, '0, 16'hFFFF, ck_reg);
  push(op_rd, ttc_pkg::ctrl, '0, ctrl_word(ttc_pkg::overflow_down, 1, 0, 0), ck_reg);
  // Divide by 4 over 40 cycles
  push(op_wr, ttc_pkg::prescale, 16'h0011, '0, ck_none);    // Enable with N = 1
  push(op_wr, ttc_pkg::ctrl, ctrl_word(ttc_pkg::overflow_up, 0, 0, 1), '0, ck_none);
  push(op_wait, ttc_pkg::ctrl, 16'd40, '0, ck_none);
  push(op_wr, ttc_pkg::ctrl, ctrl_word(ttc_pkg::overflow_up, 1, 0, 0), '0, ck_none);
  push(op_rd, ttc_pkg::count, 16'd8, 16'd11, ck_range);
endtask

// ==== bench/ttc_tb.sv ====
/*
  Table-driven testbench for the APB timer channel.
  Inputs change on the falling edge. Reads take prdata from the access edge.
*/
module ttc_tb;
  timeunit 1ns;
  timeprecision 100ps;

  logic                       pclk5;
  logic                       n_p_reset5;
  logic                       psel;
  logic                       penable;
  logic                       pwrite;
  logic [ttc_pkg::addr_w-1:0] paddr;
  logic [ttc_pkg::data_w-1:0] pwdata;
  logic [ttc_pkg::data_w-1:0] prdata;
  logic [ttc_pkg::data_w-1:0] prdata_s;    // prdata at the last rising edge
  logic                       irq;
  int                         n_chk;
  int                         n_err;
  int                         limit_cyc;   // Watchdog limit in cycles
  bit                         test_ok;

  `include "ttc_tb_table.svh"

  ttc_timer DUT (.*);

  initial
  begin
    pclk5 = 1'b0;
    forever #5 pclk5 = ~pclk5;             // 10 ns period
  end

  always @(posedge pclk5)
    prdata_s <= prdata;

  // ------------------------------
  // Compare tasks
  task automatic check_reg(input string sig, input logic [ttc_pkg::data_w-1:0] exp, act);
    n_chk++;
    if (act !== exp)
    begin
      n_err++;
      test_ok = 1'b0;
      $display("Error: time %0d ns, signal %s, expected %h, actual %h", $time, sig, exp, act);
    end
  endtask

  task automatic check_status(input string sig, input logic [ttc_pkg::intr_w-1:0] exp, act);
    n_chk++;
    if (act !== exp)
    begin
      n_err++;
      test_ok = 1'b0;
      $display("Error: time %0d ns, signal %s, expected %b, actual %b", $time, sig, exp, act);
    end
  endtask

  // Window check for counts that depend on where sampling lands
  task automatic check_range(input string sig, input logic [ttc_pkg::data_w-1:0] lo, hi, act);
    n_chk++;
    if ($isunknown(act) || act < lo || act > hi)
    begin
      n_err++;
      test_ok = 1'b0;
      $display("Error: time %0d ns, signal %s, expected %h..%h, actual %h",
               $time, sig, lo, hi, act);
    end
  endtask

  task automatic check_irq(input logic exp, act);
    n_chk++;
    if (act !== exp)
    begin
      n_err++;
      test_ok = 1'b0;
      $display("Error: time %0d ns, signal irq, expected %b, actual %b", $time, exp, act);
    end
  endtask

  // One APB transfer that starts and ends on a falling edge
  task automatic apb_xfer(input logic wr, input logic [ttc_pkg::addr_w-1:0] a,
                          input logic [ttc_pkg::data_w-1:0] d,
                          output logic [ttc_pkg::data_w-1:0] rd);
    psel    = 1'b1;                        // Setup phase
    penable = 1'b0;
    pwrite  = wr;
    paddr   = a;
    pwdata  = d;
    @(negedge pclk5);
    penable = 1'b1;                        // Access phase
    @(negedge pclk5);
    psel    = 1'b0;
    penable = 1'b0;
    rd      = prdata_s;
  endtask

  function automatic int table_cycles();
    int n;
    n = 0;
    foreach (tbl[i])
      n += (tbl[i].op == op_wait) ? int'(tbl[i].data) : 2;
    return n;
  endfunction

  // Watchdog
  initial
  begin
    wait (limit_cyc > 0);
    #(limit_cyc * 10);
    $display("Timeout after %0d cycles, the table did not complete", limit_cyc);
    $display("** FAIL **");
    $finish;
  end

  initial
  begin
    logic [ttc_pkg::data_w-1:0] rd_val;
    string                      sig;
    n_p_reset5 = 1'b0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    void'($urandom(32'h8992));
    build_table();
    limit_cyc = table_cycles() * 2 + 100;
    repeat (8) @(negedge pclk5);
    n_p_reset5 = 1'b1;
    foreach (tbl[i])
    begin
      test_ok = 1'b1;
      sig     = {"prdata.", tbl[i].addr.name()};
      case (tbl[i].op)
        op_wr: apb_xfer(1'b1, tbl[i].addr, tbl[i].data, rd_val);
        op_rd:
        begin
          apb_xfer(1'b0, tbl[i].addr, '0, rd_val);
          case (tbl[i].kind)
            ck_status: check_status(sig, tbl[i].exp[ttc_pkg::intr_w-1:0],
                                    rd_val[ttc_pkg::intr_w-1:0]);
            ck_range:  check_range(sig, tbl[i].data, tbl[i].exp, rd_val);
            default:   check_reg(sig, tbl[i].exp, rd_val);
          endcase
        end
        op_wait: repeat (tbl[i].data) @(negedge pclk5);
        default: check_irq(tbl[i].exp[0], irq);      // Stable between edges
      endcase
      $display("Test %0d %s %s: %s", i, tbl[i].op.name(), tbl[i].addr.name(),
               test_ok ? "ok" : "failed");
    end
    $display("Checks %0d, passed %0d, failed %0d", n_chk, n_chk - n_err, n_err);
    if (n_err == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+bench
hdl/ttc_pkg.sv
hdl/ttc_reg_if.sv
hdl/ttc_prescaler.sv
hdl/ttc_counter_lite.sv
hdl/ttc_regbank.sv
hdl/ttc_timer.sv
bench/ttc_tb.sv
